// ==== Makefile ====
SRCS := $(shell grep -v '^+' flist.f)

.PHONY: all run clean

all: run

obj_dir/Vgpio_tb: flist.f $(SRCS) include/gpio_tb_table.svh
	verilator --binary --timing --assert -f flist.f --top-module gpio_tb

run: obj_dir/Vgpio_tb
	obj_dir/Vgpio_tb | tee sim.log
	grep -qx 'test passed' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== flist.f ====
+incdir+include
src/gpio_pkg.sv
src/gpio_input_sync.sv
src/gpio_irq_detect.sv
src/gpio_apb_regs.sv
src/gpio_top.sv
verification/gpio_props.sv
verification/gpio_tb.sv

// ==== src/gpio_apb_regs.sv ====
`timescale 1ns/1ps

module gpio_apb_regs #(
   parameter int                 io_num      = 32,
   parameter gpio_pkg::pin_vec_t gpout_reset = '0
) (
   input  logic                  PCLK,
   input  logic                  aresetn,
   input  logic                  psel_i,
   input  logic                  penable_i,
   input  logic                  pwrite_i,
   input  gpio_pkg::apb_addr_t   paddr_i,
   input  gpio_pkg::apb_data_t   pwdata_i,
   input  gpio_pkg::pin_sample_t sample_i,
   input  gpio_pkg::pin_vec_t    intr_reg_i,
   output gpio_pkg::apb_data_t   prdata_o,
   output gpio_pkg::cfg_array_t  cfg_o,
   output gpio_pkg::pin_vec_t    clear_o,
   output gpio_pkg::pin_vec_t    gpio_out_o,
   output gpio_pkg::pin_vec_t    gpio_oe_o
);

   localparam gpio_pkg::pin_vec_t io_mask = gpio_pkg::pin_mask(io_num);

   gpio_pkg::cfg_array_t cfg_q;
   gpio_pkg::pin_vec_t   gpout_q;
   gpio_pkg::pin_vec_t   out_en;
   gpio_pkg::pin_vec_t   oe_en;
   gpio_pkg::pin_vec_t   in_en;
   gpio_pkg::pin_vec_t   gpin;
   logic [5:0]           cfg_idx;
   logic                 wr_en;
   logic                 cfg_hit;

   // --------------------
   // write decode
   // --------------------
   // access phase of an APB write
   assign wr_en = psel_i & penable_i & pwrite_i;

   // word index into the config bank
   assign cfg_idx = paddr_i[7:2];
   assign cfg_hit = (paddr_i < gpio_pkg::addr_cfg_limit) && (int'(cfg_idx) < io_num);

   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         cfg_q <= '0;
      else if (wr_en && cfg_hit)
         cfg_q[cfg_idx[4:0]] <= gpio_pkg::pin_cfg_t'(pwdata_i[7:0]);
   end

   // output register, unused pins kept at zero
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         gpout_q <= gpout_reset & io_mask;
      else if (wr_en && (paddr_i == gpio_pkg::addr_gpout))
         gpout_q <= pwdata_i & io_mask;
   end

   // write ones to clear sticky bits
   assign clear_o = (wr_en && (paddr_i == gpio_pkg::addr_intr)) ? pwdata_i : '0;

   assign cfg_o = cfg_q;

   // split config fields into pin vectors
   always_comb
   begin
      for (int i = 0; i < gpio_pkg::gpio_max; i++)
      begin
         out_en[i] = cfg_q[i].out_en;
         oe_en[i]  = cfg_q[i].oe_en;
         in_en[i]  = cfg_q[i].in_en;
      end
   end

   // input value as seen by software
   assign gpin = sample_i.prev & in_en;

   // --------------------
   // read mux
   // --------------------
   always_comb
   begin
      prdata_o = '0;
      if (paddr_i < gpio_pkg::addr_cfg_limit)
      begin
         if (cfg_hit)
            prdata_o = {24'h0, cfg_q[cfg_idx[4:0]]};
      end
      else
      begin
         case (paddr_i)
            gpio_pkg::addr_intr:  prdata_o = intr_reg_i;
            gpio_pkg::addr_gpin:  prdata_o = gpin;
            gpio_pkg::addr_gpout: prdata_o = gpout_q;
            default:              prdata_o = '0;
         endcase
      end
   end

   // --------------------
   // pin drive
   // --------------------
   assign gpio_out_o = gpout_q & out_en;
   // enable needs the output path on as well
   assign gpio_oe_o  = oe_en & out_en;

endmodule

// ==== src/gpio_input_sync.sv ====
`timescale 1ns/1ps

module gpio_input_sync #(
   parameter int io_num = 32
) (
   input  logic                  PCLK,
   input  logic                  aresetn,
   input  gpio_pkg::pin_vec_t    gpio_in_i,
   output gpio_pkg::pin_sample_t sample_o
);

   localparam gpio_pkg::pin_vec_t io_mask = gpio_pkg::pin_mask(io_num);

   gpio_pkg::pin_vec_t gpin1;
   gpio_pkg::pin_vec_t gpin2;
   gpio_pkg::pin_vec_t gpin3;

   // three flop stages, unused pins stay at zero
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         gpin1 <= '0;
         gpin2 <= '0;
         gpin3 <= '0;
      end
      else
      begin
         gpin1 <= gpio_in_i & io_mask;
         gpin2 <= gpin1;
         gpin3 <= gpin2;
      end
   end

   // cur after two edges, prev after three
   assign sample_o.cur  = gpin2;
   assign sample_o.prev = gpin3;

endmodule

// ==== src/gpio_irq_detect.sv ====
`timescale 1ns/1ps

module gpio_irq_detect #(
   parameter int io_num = 32
) (
   input  logic                  PCLK,
   input  logic                  aresetn,
   input  gpio_pkg::pin_sample_t sample_i,
   input  gpio_pkg::cfg_array_t  cfg_i,
   input  gpio_pkg::pin_vec_t    clear_i,
   output gpio_pkg::pin_vec_t    intr_reg_o,
   output gpio_pkg::pin_vec_t    int_o,
   output logic                  int_or_o
);

   localparam gpio_pkg::pin_vec_t io_mask = gpio_pkg::pin_mask(io_num);

   gpio_pkg::pin_vec_t int_en;
   gpio_pkg::pin_vec_t rise;
   gpio_pkg::pin_vec_t fall;
   gpio_pkg::pin_vec_t toggle;
   gpio_pkg::pin_vec_t edge_pos_q;
   gpio_pkg::pin_vec_t edge_neg_q;
   gpio_pkg::pin_vec_t edge_both_q;
   gpio_pkg::pin_vec_t int_sel;
   gpio_pkg::pin_vec_t intr_q;
   logic               clear_cycle;

   // enables only for pins that exist
   always_comb
   begin
      for (int i = 0; i < gpio_pkg::gpio_max; i++)
      begin
         int_en[i] = cfg_i[i].int_en & io_mask[i];
      end
   end

   // edges seen between the last two samples
   assign rise   = sample_i.cur & ~sample_i.prev;
   assign fall   = ~sample_i.cur & sample_i.prev;
   assign toggle = sample_i.cur ^ sample_i.prev;

   // --------------------
   // edge latches
   // --------------------
   // a new edge beats a clear, int_en low drops the latch
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
      begin
         edge_pos_q  <= '0;
         edge_neg_q  <= '0;
         edge_both_q <= '0;
      end
      else
      begin
         edge_pos_q  <= int_en & (rise | (edge_pos_q & ~clear_i));
         edge_neg_q  <= int_en & (fall | (edge_neg_q & ~clear_i));
         edge_both_q <= int_en & (toggle | (edge_both_q & ~clear_i));
      end
   end

   // --------------------
   // type select
   // --------------------
   always_comb
   begin
      for (int i = 0; i < gpio_pkg::gpio_max; i++)
      begin
         case (cfg_i[i].int_type)
            gpio_pkg::int_level_high: int_sel[i] = sample_i.prev[i];
            gpio_pkg::int_level_low:  int_sel[i] = ~sample_i.prev[i];
            gpio_pkg::int_edge_pos:   int_sel[i] = edge_pos_q[i];
            gpio_pkg::int_edge_neg:   int_sel[i] = edge_neg_q[i];
            gpio_pkg::int_edge_both:  int_sel[i] = edge_both_q[i];
            default:                  int_sel[i] = 1'b0;
         endcase
      end
   end

   assign int_o    = int_sel & int_en;
   assign int_or_o = |int_o;

   // --------------------
   // sticky register
   // --------------------
   assign clear_cycle = |clear_i;

   // loads live interrupts, holds minus cleared bits on a clear write
   always_ff @(posedge PCLK or negedge aresetn)
   begin
      if (!aresetn)
         intr_q <= '0;
      else if (clear_cycle)
         intr_q <= intr_q & ~clear_i;
      else
         intr_q <= int_o;
   end

   assign intr_reg_o = intr_q;

endmodule

// ==== src/gpio_pkg.sv ====
// shared types and constants for the APB GPIO block
package gpio_pkg;

   // --------------------
   // widths
   // --------------------
   localparam int gpio_max = 32;

   // one bit per pin
   typedef logic [gpio_max-1:0] pin_vec_t;
   typedef logic [31:0]         apb_data_t;
   // byte address on APB
   typedef logic [7:0]          apb_addr_t;

   // --------------------
   // interrupt type codes
   // --------------------
   typedef logic [2:0] int_type_t;

   localparam int_type_t int_level_high = 3'd0;
   localparam int_type_t int_level_low  = 3'd1;
   localparam int_type_t int_edge_pos   = 3'd2;
   localparam int_type_t int_edge_neg   = 3'd3;
   localparam int_type_t int_edge_both  = 3'd4;
   // codes 5 to 7 give no interrupt

   // per-pin configuration byte
   typedef struct packed {
      int_type_t int_type;
      logic      rsvd;
      logic      int_en;
      logic      oe_en;
      logic      in_en;
      logic      out_en;
   } pin_cfg_t;

   // all config bytes, pin 0 in the low byte
   typedef pin_cfg_t [gpio_max-1:0] cfg_array_t;

   // synchronizer taps
   typedef struct packed {
      pin_vec_t cur;
      pin_vec_t prev;
   } pin_sample_t;

   // --------------------
   // register map
   // --------------------
   localparam apb_addr_t addr_cfg_limit = 8'h80;
   localparam apb_addr_t addr_intr      = 8'h80;
   localparam apb_addr_t addr_gpin      = 8'h90;
   localparam apb_addr_t addr_gpout     = 8'hA0;

   // ones for the pins that exist
   function automatic pin_vec_t pin_mask(input int n);
      pin_vec_t mask;
      mask = '0;
      for (int i = 0; i < gpio_max; i++)
      begin
         if (i < n)
            mask[i] = 1'b1;
      end
      return mask;
   endfunction

endpackage

// ==== src/gpio_top.sv ====
`timescale 1ns/1ps

module gpio_top #(
   parameter int                 io_num      = 32,
   parameter gpio_pkg::pin_vec_t gpout_reset = '0
) (
   input  logic                PCLK,
   input  logic                aresetn,
   // APB slave
   input  logic                psel_i,
   input  logic                penable_i,
   input  logic                pwrite_i,
   input  gpio_pkg::apb_addr_t paddr_i,
   input  gpio_pkg::apb_data_t pwdata_i,
   output gpio_pkg::apb_data_t prdata_o,
   output logic                pready_o,
   output logic                pslverr_o,
   // pins
   input  gpio_pkg::pin_vec_t  gpio_in_i,
   output gpio_pkg::pin_vec_t  gpio_out_o,
   output gpio_pkg::pin_vec_t  gpio_oe_o,
   // interrupts
   output gpio_pkg::pin_vec_t  int_o,
   output logic                int_or_o
);

   gpio_pkg::pin_sample_t sample;
   gpio_pkg::cfg_array_t  cfg;
   gpio_pkg::pin_vec_t    clear_mask;
   gpio_pkg::pin_vec_t    intr_reg;

   // no wait states, no errors
   assign pready_o  = 1'b1;
   assign pslverr_o = 1'b0;

   gpio_input_sync #(
      .io_num (io_num)
   ) sync_inst (
      .PCLK      (PCLK),
      .aresetn   (aresetn),
      .gpio_in_i (gpio_in_i),
      .sample_o  (sample)
   );

   gpio_irq_detect #(
      .io_num (io_num)
   ) detect_inst (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .sample_i   (sample),
      .cfg_i      (cfg),
      .clear_i    (clear_mask),
      .intr_reg_o (intr_reg),
      .int_o      (int_o),
      .int_or_o   (int_or_o)
   );

   gpio_apb_regs #(
      .io_num      (io_num),
      .gpout_reset (gpout_reset)
   ) regs_inst (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .psel_i     (psel_i),
      .penable_i  (penable_i),
      .pwrite_i   (pwrite_i),
      .paddr_i    (paddr_i),
      .pwdata_i   (pwdata_i),
      .sample_i   (sample),
      .intr_reg_i (intr_reg),
      .prdata_o   (prdata_o),
      .cfg_o      (cfg),
      .clear_o    (clear_mask),
      .gpio_out_o (gpio_out_o),
      .gpio_oe_o  (gpio_oe_o)
   );

endmodule

// ==== verification/gpio_props.sv ====
`timescale 1ns/1ps

module gpio_props (
   input logic                 PCLK,
   input logic                 aresetn,
   input gpio_pkg::cfg_array_t cfg_i,
   input gpio_pkg::pin_vec_t   gpio_out_i,
   input gpio_pkg::pin_vec_t   gpio_oe_i,
   input gpio_pkg::pin_vec_t   int_i,
   input logic                 int_or_i
);

   gpio_pkg::pin_vec_t out_en;
   int                 fail_count = 0;

   always_comb
   begin
      for (int i = 0; i < gpio_pkg::gpio_max; i++)
         out_en[i] = cfg_i[i].out_en;
   end

   // output enable only where the output path is on
   oe_needs_out_en: assert property (@(posedge PCLK) disable iff (!aresetn)
      (gpio_oe_i & ~out_en) == '0)
   else
   begin
      $error("gpio_oe_o set on a pin without out_en");
      fail_count++;
   end

   int_or_matches: assert property (@(posedge PCLK) int_or_i == |int_i)
   else
   begin
      $error("int_or_o differs from the OR of int_o");
      fail_count++;
   end

   quiet_in_reset: assert property (@(posedge PCLK) !aresetn |->
      (gpio_out_i == '0 && gpio_oe_i == '0 && int_i == '0 && !int_or_i))
   else
   begin
      $error("output not zero during reset");
      fail_count++;
   end

endmodule

bind gpio_top gpio_props props_inst (
   .PCLK       (PCLK),
   .aresetn    (aresetn),
   .cfg_i      (cfg),
   .gpio_out_i (gpio_out_o),
   .gpio_oe_i  (gpio_oe_o),
   .int_i      (int_o),
   .int_or_i   (int_or_o)
);

// ==== include/gpio_tb_table.svh ====
`ifndef GPIO_TB_TABLE_SVH
`define GPIO_TB_TABLE_SVH

// each row holds test id, operation, address, data (config byte or pin pattern) and expected
// expected is read data, int_o or gpio_out_o, and op_drv rows keep gpio_oe_o in data

localparam logic [2:0] op_wr  = 3'd0;
localparam logic [2:0] op_rd  = 3'd1;
localparam logic [2:0] op_pin = 3'd2;
localparam logic [2:0] op_int = 3'd3;
localparam logic [2:0] op_drv = 3'd4;

typedef struct packed {
   logic [3:0]  id;
   logic [2:0]  op;
   logic [7:0]  addr;
   logic [31:0] data;
   logic [31:0] exp;
} row_t;

localparam int n_rows = 51;

localparam row_t table_rows [n_rows] = '{
   // reset value, config readback, unmapped reads
   '{4'd1, op_rd,  8'hA0, 32'h00, 32'h00A5_0F3C},
   '{4'd1, op_drv, 8'h00, 32'h00, 32'h00},
   '{4'd1, op_wr,  8'h08, 32'hFF, 32'h00},
   '{4'd1, op_rd,  8'h08, 32'h00, 32'hFF},
   '{4'd1, op_drv, 8'h00, 32'h04, 32'h04},
   '{4'd1, op_wr,  8'h60, 32'hFF, 32'h00},
   '{4'd1, op_rd,  8'h60, 32'h00, 32'h00},
   '{4'd1, op_rd,  8'hB0, 32'h00, 32'h00},
   // level high, then level low on pin 0
   '{4'd4, op_wr,  8'h00, 32'h0A, 32'h00},
   '{4'd4, op_pin, 8'h00, 32'h01, 32'h00},
   '{4'd4, op_int, 8'h00, 32'h00, 32'h01},
   '{4'd4, op_wr,  8'h80, 32'h01, 32'h00},
   '{4'd4, op_rd,  8'h80, 32'h00, 32'h01},
   '{4'd4, op_pin, 8'h00, 32'h00, 32'h00},
   '{4'd4, op_int, 8'h00, 32'h00, 32'h00},
   '{4'd4, op_wr,  8'h00, 32'h2A, 32'h00},
   '{4'd4, op_int, 8'h00, 32'h00, 32'h01},
   '{4'd4, op_pin, 8'h00, 32'h01, 32'h00},
   '{4'd4, op_int, 8'h00, 32'h00, 32'h00},
   // rising edge
   '{4'd5, op_wr,  8'h00, 32'h00, 32'h00},
   '{4'd5, op_wr,  8'h00, 32'h4A, 32'h00},
   '{4'd5, op_pin, 8'h00, 32'h00, 32'h00},
   '{4'd5, op_int, 8'h00, 32'h00, 32'h00},
   '{4'd5, op_pin, 8'h00, 32'h01, 32'h00},
   '{4'd5, op_int, 8'h00, 32'h00, 32'h01},
   '{4'd5, op_pin, 8'h00, 32'h00, 32'h00},
   '{4'd5, op_rd,  8'h80, 32'h00, 32'h01},
   '{4'd5, op_wr,  8'h80, 32'h01, 32'h00},
   '{4'd5, op_rd,  8'h80, 32'h00, 32'h00},
   // falling edge and the latch drop on int_en off
   '{4'd6, op_wr,  8'h00, 32'h00, 32'h00},
   '{4'd6, op_wr,  8'h00, 32'h6A, 32'h00},
   '{4'd6, op_pin, 8'h00, 32'h01, 32'h00},
   '{4'd6, op_int, 8'h00, 32'h00, 32'h00},
   '{4'd6, op_pin, 8'h00, 32'h00, 32'h00},
   '{4'd6, op_pin, 8'h00, 32'h01, 32'h00},
   '{4'd6, op_rd,  8'h80, 32'h00, 32'h01},
   '{4'd6, op_wr,  8'h80, 32'h01, 32'h00},
   '{4'd6, op_rd,  8'h80, 32'h00, 32'h00},
   '{4'd6, op_pin, 8'h00, 32'h00, 32'h00},
   '{4'd6, op_int, 8'h00, 32'h00, 32'h01},
   '{4'd6, op_wr,  8'h00, 32'h62, 32'h00},
   '{4'd6, op_wr,  8'h00, 32'h6A, 32'h00},
   '{4'd6, op_int, 8'h00, 32'h00, 32'h00},
   // both edges
   '{4'd7, op_wr,  8'h00, 32'h8A, 32'h00},
   '{4'd7, op_pin, 8'h00, 32'h01, 32'h00},
   '{4'd7, op_int, 8'h00, 32'h00, 32'h01},
   '{4'd7, op_wr,  8'h80, 32'h01, 32'h00},
   '{4'd7, op_int, 8'h00, 32'h00, 32'h00},
   '{4'd7, op_rd,  8'h80, 32'h00, 32'h00},
   '{4'd7, op_pin, 8'h00, 32'h00, 32'h00},
   '{4'd7, op_rd,  8'h80, 32'h00, 32'h01}
};

`endif

// ==== verification/gpio_tb.sv ====
`timescale 1ns/1ps

module gpio_tb;

   localparam int                 io_num      = 24;
   localparam gpio_pkg::pin_vec_t gpout_reset = 32'h00A5_0F3C;
   // pins at and above io_num read zero
   localparam gpio_pkg::pin_vec_t io_mask     = (32'h1 << io_num) - 32'h1;

   `include "gpio_tb_table.svh"

   localparam int drive_iters = 3;
   localparam int input_iters = 6;
   // a pin change row is the longest, six cycles
   localparam int test_cycles = n_rows * 6 + drive_iters * (io_num + 2) * 3 + input_iters * 10;
   localparam int cycle_limit = 2 * test_cycles + 16;

   logic                PCLK;
   logic                aresetn;
   logic                psel;
   logic                penable;
   logic                pwrite;
   gpio_pkg::apb_addr_t paddr;
   gpio_pkg::apb_data_t pwdata;
   gpio_pkg::apb_data_t prdata;
   logic                pready;
   logic                pslverr;
   gpio_pkg::pin_vec_t  gpio_in;
   gpio_pkg::pin_vec_t  gpio_out;
   gpio_pkg::pin_vec_t  gpio_oe;
   gpio_pkg::pin_vec_t  int_vec;
   logic                int_or;

   // config bits written by the random tests
   gpio_pkg::pin_vec_t  out_en_v;
   gpio_pkg::pin_vec_t  oe_en_v;
   gpio_pkg::pin_vec_t  in_en_v;
   logic [31:0]         rng_state;
   int                  cycle_count;
   int                  err_count;
   int                  check_count;
   int                  tests_run;
   int                  tests_failed;

   gpio_top #(
      .io_num      (io_num),
      .gpout_reset (gpout_reset)
   ) gpio_top_inst (
      .PCLK       (PCLK),
      .aresetn    (aresetn),
      .psel_i     (psel),
      .penable_i  (penable),
      .pwrite_i   (pwrite),
      .paddr_i    (paddr),
      .pwdata_i   (pwdata),
      .prdata_o   (prdata),
      .pready_o   (pready),
      .pslverr_o  (pslverr),
      .gpio_in_i  (gpio_in),
      .gpio_out_o (gpio_out),
      .gpio_oe_o  (gpio_oe),
      .int_o      (int_vec),
      .int_or_o   (int_or)
   );

   always #5 PCLK = ~PCLK;

   always @(posedge PCLK)
   begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit)
      begin
         $display("timeout: the tests did not finish within %0d cycles", cycle_limit);
         $display("test failed");
         $finish;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
      check_count++;
      if (got !== exp)
      begin
         err_count++;
         $display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   // --------------------
   // APB access
   // --------------------
   task automatic apb_write(input gpio_pkg::apb_addr_t addr, input logic [31:0] data);
      @(posedge PCLK);
      #1;
      psel = 1'b1;
      pwrite = 1'b1;
      paddr = addr;
      pwdata = data;
      @(posedge PCLK);
      #1;
      penable = 1'b1;
      @(posedge PCLK);
      #1;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
   endtask

   task automatic apb_read(input gpio_pkg::apb_addr_t addr, output logic [31:0] data);
      @(posedge PCLK);
      #1;
      psel = 1'b1;
      pwrite = 1'b0;
      paddr = addr;
      @(posedge PCLK);
      #1;
      penable = 1'b1;
      // mid cycle, well away from register updates
      @(negedge PCLK);
      data = prdata;
      check_value("pready_o", {31'h0, pready}, 32'h1);
      check_value("pslverr_o", {31'h0, pslverr}, 32'h0);
      @(posedge PCLK);
      #1;
      psel = 1'b0;
      penable = 1'b0;
   endtask

   task automatic finish_test(input int id, input int errs_before);
      tests_run++;
      if (err_count != errs_before)
         tests_failed++;
      $display("test %0d done, %0d errors", id, err_count - errs_before);
   endtask

   task automatic apply_row(input row_t row);
      logic [31:0] rd;
      case (row.op)
         op_wr: apb_write(row.addr, row.data);
         op_rd:
         begin
            apb_read(row.addr, rd);
            check_value("prdata_o", rd, row.exp);
         end
         op_pin:
         begin
            @(posedge PCLK);
            #1;
            gpio_in = row.data;
            repeat (5) @(posedge PCLK);
         end
         op_int:
         begin
            @(negedge PCLK);
            check_value("int_o", int_vec, row.exp);
            check_value("int_or_o", {31'h0, int_or}, {31'h0, |row.exp});
         end
         default:
         begin
            @(negedge PCLK);
            check_value("gpio_out_o", gpio_out, row.exp);
            check_value("gpio_oe_o", gpio_oe, row.data);
         end
      endcase
   endtask

   task automatic run_table_test(input int id);
      int errs_before;
      errs_before = err_count;
      for (int i = 0; i < n_rows; i++)
      begin
         if (int'(table_rows[i].id) == id)
            apply_row(table_rows[i]);
      end
      finish_test(id, errs_before);
   endtask

   // --------------------
   // random tests
   // --------------------
   task automatic drive_test();
      int          errs_before;
      logic [31:0] gpout;
      logic [31:0] rd;
      errs_before = err_count;
      for (int n = 0; n < drive_iters; n++)
      begin
         // random out_en, in_en and oe_en, interrupts off
         for (int p = 0; p < io_num; p++)
         begin
            rng_state = xorshift32(rng_state);
            out_en_v[p] = rng_state[0];
            in_en_v[p] = rng_state[1];
            oe_en_v[p] = rng_state[2];
            apb_write(8'(p * 4), {29'h0, rng_state[2:0]});
         end
         rng_state = xorshift32(rng_state);
         gpout = rng_state;
         apb_write(gpio_pkg::addr_gpout, gpout);
         @(negedge PCLK);
         check_value("gpio_out_o", gpio_out, gpout & io_mask & out_en_v);
         check_value("gpio_oe_o", gpio_oe, oe_en_v & out_en_v);
         apb_read(gpio_pkg::addr_gpout, rd);
         check_value("prdata_o", rd, gpout & io_mask);
      end
      finish_test(2, errs_before);
   endtask

   task automatic input_test();
      int          errs_before;
      logic [31:0] pins;
      logic [31:0] rd;
      errs_before = err_count;
      for (int n = 0; n < input_iters; n++)
      begin
         rng_state = xorshift32(rng_state);
         pins = rng_state;
         @(posedge PCLK);
         #1;
         gpio_in = pins;
         repeat (5) @(posedge PCLK);
         apb_read(gpio_pkg::addr_gpin, rd);
         check_value("prdata_o", rd, pins & io_mask & in_en_v);
      end
      finish_test(3, errs_before);
   endtask

   initial
   begin
      PCLK = 1'b0;
      aresetn = 1'b0;
      psel = 1'b0;
      penable = 1'b0;
      pwrite = 1'b0;
      paddr = '0;
      pwdata = '0;
      gpio_in = '0;
      out_en_v = '0;
      oe_en_v = '0;
      in_en_v = '0;
      rng_state = 32'he6d1;
      cycle_count = 0;
      err_count = 0;
      check_count = 0;
      tests_run = 0;
      tests_failed = 0;
      repeat (16) @(posedge PCLK);
      #1;
      aresetn = 1'b1;

      run_table_test(1);
      drive_test();
      input_test();
      for (int id = 4; id <= 7; id++)
         run_table_test(id);

      if (gpio_top_inst.props_inst.fail_count != 0)
      begin
         $display("bound assertions failed %0d times", gpio_top_inst.props_inst.fail_count);
         err_count += gpio_top_inst.props_inst.fail_count;
      end
      $display("%0d tests, %0d failed, %0d checks, %0d errors",
               tests_run, tests_failed, check_count, err_count);
      if (err_count == 0)
         $display("test passed");
      else
         $display("test failed");
      $finish;
   end

endmodule
